//--- files.f
source/agen_pkg.sv
source/agen_input_fifo.sv
source/gpr_size_view.sv
source/string_address.sv
source/operand_select.sv
source/agen_output_stage.sv
source/address_generation_top.sv
tests/agen_asserts.sv
tests/tb_address_generation.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the address generation testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_address_generation -f files.f -o sim_tb

# a failing run still prints its output, the search decides the status
out=$(./obj_dir/sim_tb 2>&1 || true)
echo "$out"
grep -qF '*** PASSED ***' <<< "$out"

//--- source/address_generation_top.sv
// top of the address generation operand fetch stage
// input FIFO, register views, string addresses, two operand selectors
// and the registered output stage
`timescale 1ns/1ps

module address_generation_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   r_valid,
    input  agen_pkg::agen_req_t    r_req,
    input  agen_pkg::arch_state_t  arch,
    input  logic                   a_credit,
    output logic                   r_credit,
    output logic                   a_valid,
    output agen_pkg::agen_result_t a_result
);

    agen_pkg::agen_req_t         head;
    logic                        not_empty;
    logic                        pop;
    agen_pkg::view_file_t        views;
    logic [agen_pkg::addr_w-1:0] dst_addr;
    logic [agen_pkg::addr_w-1:0] src_addr;
    logic [agen_pkg::op_w-1:0]   op0_value;
    logic [agen_pkg::op_w-1:0]   op1_value;
    logic                        op0_is_address;
    logic                        op1_is_address;

    agen_input_fifo input_fifo0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .r_valid   (r_valid),
        .r_req     (r_req),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .r_credit  (r_credit)
    );

    gpr_size_view size_view0 (
        .size  (head.size),
        .arch  (arch),
        .views (views)
    );

    string_address string_address0 (
        .arch               (arch),
        .seg_override       (head.seg_override),
        .seg_override_valid (head.seg_override_valid),
        .dst_addr           (dst_addr),
        .src_addr           (src_addr)
    );

    // op0 strings use es:edi
    operand_select op0_select0 (
        .kind       (head.op0_kind),
        .reg_idx    (head.op0_reg),
        .views      (views),
        .segs       (arch.segs),
        .imm        (head.imm),
        .mem_addr   (dst_addr),
        .value      (op0_value),
        .is_address (op0_is_address)
    );

    // op1 strings use ds:esi or the override
    operand_select op1_select0 (
        .kind       (head.op1_kind),
        .reg_idx    (head.op1_reg),
        .views      (views),
        .segs       (arch.segs),
        .imm        (head.imm),
        .mem_addr   (src_addr),
        .value      (op1_value),
        .is_address (op1_is_address)
    );

    agen_output_stage output_stage0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .not_empty      (not_empty),
        .head           (head),
        .op0            (op0_value),
        .op0_is_address (op0_is_address),
        .op1            (op1_value),
        .op1_is_address (op1_is_address),
        .a_credit       (a_credit),
        .pop            (pop),
        .a_valid        (a_valid),
        .a_result       (a_result)
    );

endmodule

//--- source/agen_input_fifo.sv
// two-entry request FIFO in front of the operand fetch logic
// circular buffer with read and write pointers
// returns one input credit per pop
`timescale 1ns/1ps

module agen_input_fifo (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                r_valid,
    input  agen_pkg::agen_req_t r_req,
    input  logic                pop,
    output agen_pkg::agen_req_t head,
    output logic                not_empty,
    output logic                r_credit
);

    agen_pkg::agen_req_t mem [agen_pkg::agen_in_credits];

    logic [agen_pkg::in_ptr_w-1:0] wr_ptr;
    logic [agen_pkg::in_ptr_w-1:0] rd_ptr;
    logic [agen_pkg::in_cnt_w-1:0] count;
    logic                          full;
    logic                          do_write;
    logic                          do_pop;

    assign full      = (count == agen_pkg::in_cnt_w'(agen_pkg::agen_in_credits));
    assign not_empty = (count != '0);
    // a write into a full FIFO is dropped
    assign do_write  = r_valid && !full;
    assign do_pop    = pop && not_empty;
    assign r_credit  = do_pop;
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= r_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                if (wr_ptr == agen_pkg::in_ptr_w'(agen_pkg::agen_in_credits - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == agen_pkg::in_ptr_w'(agen_pkg::agen_in_credits - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({do_write, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/agen_output_stage.sv
// registered output of the address generation stage
// downstream credit counter, pop control and result register
`timescale 1ns/1ps

module agen_output_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         not_empty,
    input  agen_pkg::agen_req_t          head,
    input  logic [agen_pkg::op_w-1:0]    op0,
    input  logic                         op0_is_address,
    input  logic [agen_pkg::op_w-1:0]    op1,
    input  logic                         op1_is_address,
    input  logic                         a_credit,
    output logic                         pop,
    output logic                         a_valid,
    output agen_pkg::agen_result_t       a_result
);

    logic [agen_pkg::out_cnt_w-1:0] credits;
    agen_pkg::agen_result_t         result_next;

    // one slot downstream is needed per result
    assign pop = not_empty && (credits != '0);

    always_comb begin
        result_next.op0            = op0;
        result_next.op1            = op1;
        result_next.op0_is_address = op0_is_address;
        result_next.op1_is_address = op1_is_address;
        result_next.alu_op         = head.alu_op;
        result_next.pc             = head.pc;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= agen_pkg::out_cnt_w'(agen_pkg::agen_out_credits);
        end else begin
            case ({pop, a_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_valid <= 1'b0;
        end else begin
            a_valid <= pop;
        end
    end

    // result payload, captured on each pop
    always_ff @(posedge clk) begin
        if (pop) begin
            a_result <= result_next;
        end
    end

endmodule

//--- source/agen_pkg.sv
// shared constants and types for the address generation stage
// operand kind, size and segment codes, register word union
// request, architectural state and result structs, segment lookup
package agen_pkg;

    // credit pools on the two sides
    localparam int agen_in_credits  = 2;
    localparam int agen_out_credits = 4;

    localparam int in_ptr_w  = (agen_in_credits > 1) ? $clog2(agen_in_credits) : 1;
    localparam int in_cnt_w  = $clog2(agen_in_credits + 1);
    localparam int out_cnt_w = $clog2(agen_out_credits + 1);

    localparam int op_w     = 64;
    localparam int imm_w    = 48;
    localparam int addr_w   = 32;
    localparam int num_gprs = 8;
    localparam int num_segs = 6;

    // operand kinds, codes 3 and 4 are reserved and read as zero
    typedef logic [2:0] op_kind_t;
    localparam op_kind_t kind_none = 3'd0;
    localparam op_kind_t kind_reg  = 3'd1;
    localparam op_kind_t kind_seg  = 3'd2;
    localparam op_kind_t kind_imm  = 3'd5;
    localparam op_kind_t kind_mem  = 3'd6;

    typedef logic [2:0] op_size_t;
    localparam op_size_t size_8  = 3'd1;
    localparam op_size_t size_16 = 3'd2;
    localparam op_size_t size_32 = 3'd3;

    // segment register order in the state
    typedef logic [2:0] seg_idx_t;
    localparam seg_idx_t seg_es = 3'd0;
    localparam seg_idx_t seg_cs = 3'd1;
    localparam seg_idx_t seg_ss = 3'd2;
    localparam seg_idx_t seg_ds = 3'd3;
    localparam seg_idx_t seg_fs = 3'd4;
    localparam seg_idx_t seg_gs = 3'd5;

    // string instruction index registers
    localparam logic [2:0] gpr_esi = 3'd6;
    localparam logic [2:0] gpr_edi = 3'd7;

    // one gpr seen as a dword or as its byte parts
    typedef union packed {
        logic [31:0] dword;
        struct packed {
            logic [15:0] upper;
            logic [7:0]  hi;
            logic [7:0]  lo;
        } parts;
    } gpr_word_u;

    typedef logic [num_segs-1:0][15:0] seg_file_t;
    typedef logic [num_gprs-1:0][op_w-1:0] view_file_t;

    typedef struct packed {
        op_size_t         size;
        op_kind_t         op0_kind;
        op_kind_t         op1_kind;
        logic [2:0]       op0_reg;
        logic [2:0]       op1_reg;
        seg_idx_t         seg_override;
        logic             seg_override_valid;
        logic [imm_w-1:0] imm;
        logic [3:0]       alu_op;
        logic [31:0]      pc;
    } agen_req_t;

    typedef struct packed {
        gpr_word_u [num_gprs-1:0] gpr;
        seg_file_t                segs;
    } arch_state_t;

    typedef struct packed {
        logic [op_w-1:0] op0;
        logic [op_w-1:0] op1;
        logic            op0_is_address;
        logic            op1_is_address;
        logic [3:0]      alu_op;
        logic [31:0]     pc;
    } agen_result_t;

    // segment value by index, 6 and 7 read zero
    function automatic logic [15:0] seg_value(seg_file_t segs, seg_idx_t idx);
        logic [15:0] value;
        case (idx)
            seg_es:  value = segs[seg_es];
            seg_cs:  value = segs[seg_cs];
            seg_ss:  value = segs[seg_ss];
            seg_ds:  value = segs[seg_ds];
            seg_fs:  value = segs[seg_fs];
            seg_gs:  value = segs[seg_gs];
            default: value = 16'h0000;
        endcase
        return value;
    endfunction

endpackage

//--- source/gpr_size_view.sv
// sized views of the eight general registers
// 8-bit gives al..bl then ah..bh, 16 and 32 give the low half or dword
`timescale 1ns/1ps

module gpr_size_view (
    input  agen_pkg::op_size_t    size,
    input  agen_pkg::arch_state_t arch,
    output agen_pkg::view_file_t  views
);

    always_comb begin
        views = '0;
        case (size)
            agen_pkg::size_8: begin
                // only eax..ebx have byte registers
                for (int i = 0; i < 4; i++) begin
                    views[i]     = {56'd0, arch.gpr[i].parts.lo};
                    views[i + 4] = {56'd0, arch.gpr[i].parts.hi};
                end
            end
            agen_pkg::size_16: begin
                for (int i = 0; i < agen_pkg::num_gprs; i++) begin
                    views[i] = {48'd0, arch.gpr[i].parts.hi, arch.gpr[i].parts.lo};
                end
            end
            agen_pkg::size_32: begin
                for (int i = 0; i < agen_pkg::num_gprs; i++) begin
                    views[i] = {32'd0, arch.gpr[i].dword};
                end
            end
            default: begin
                // unsupported sizes read zero
                views = '0;
            end
        endcase
    end

endmodule

//--- source/operand_select.sv
// resolves one operand to a 64-bit value and an address flag
// kinds are none, register, segment, immediate and string memory
`timescale 1ns/1ps

module operand_select (
    input  agen_pkg::op_kind_t          kind,
    input  logic [2:0]                  reg_idx,
    input  agen_pkg::view_file_t        views,
    input  agen_pkg::seg_file_t         segs,
    input  logic [agen_pkg::imm_w-1:0]  imm,
    input  logic [agen_pkg::addr_w-1:0] mem_addr,
    output logic [agen_pkg::op_w-1:0]   value,
    output logic                        is_address
);

    logic [15:0] seg_sel;

    assign seg_sel = agen_pkg::seg_value(segs, reg_idx);

    always_comb begin
        case (kind)
            agen_pkg::kind_none: begin
                value = '0;
            end
            agen_pkg::kind_reg: begin
                value = views[reg_idx];
            end
            agen_pkg::kind_seg: begin
                value = {48'd0, seg_sel};
            end
            agen_pkg::kind_imm: begin
                // 48-bit immediate, zero-extended
                value = {16'd0, imm};
            end
            agen_pkg::kind_mem: begin
                value = {32'd0, mem_addr};
            end
            default: begin
                // reserved codes 3, 4 and 7
                value = '0;
            end
        endcase
    end

    assign is_address = (kind == agen_pkg::kind_mem);

endmodule

//--- source/string_address.sv
// linear addresses for string operands
// es:edi for the destination, ds or override:esi for the source
`timescale 1ns/1ps

module string_address (
    input  agen_pkg::arch_state_t     arch,
    input  agen_pkg::seg_idx_t        seg_override,
    input  logic                      seg_override_valid,
    output logic [agen_pkg::addr_w-1:0] dst_addr,
    output logic [agen_pkg::addr_w-1:0] src_addr
);

    logic [15:0] es_value;
    logic [15:0] src_seg;
    logic [31:0] es_base;
    logic [31:0] src_base;

    // destination segment is never overridden
    assign es_value = agen_pkg::seg_value(arch.segs, agen_pkg::seg_es);

    always_comb begin
        if (seg_override_valid) begin
            src_seg = agen_pkg::seg_value(arch.segs, seg_override);
        end else begin
            src_seg = agen_pkg::seg_value(arch.segs, agen_pkg::seg_ds);
        end
    end

    // real mode style base, segment times 16
    assign es_base  = {12'd0, es_value, 4'd0};
    assign src_base = {12'd0, src_seg, 4'd0};

    // sums wrap at 32 bits
    assign dst_addr = es_base + arch.gpr[agen_pkg::gpr_edi].dword;
    assign src_addr = src_base + arch.gpr[agen_pkg::gpr_esi].dword;

endmodule

//--- tests/agen_asserts.sv
// credit protocol assertions for the address generation top
// quiet reset, output credit bound, no write into a full FIFO
`timescale 1ns/1ps

module agen_asserts (
    input logic clk,
    input logic rst_n,
    input logic r_valid,
    input logic r_credit,
    input logic pop,
    input logic a_valid,
    input logic a_credit
);

    int   in_used;
    int   out_used;
    logic in_reset_q;

    // FIFO occupancy and results not yet returned downstream
    always_ff @(posedge clk) begin
        in_reset_q <= !rst_n;
        if (!rst_n) begin
            in_used  <= 0;
            out_used <= 0;
        end else begin
            in_used  <= in_used + int'(r_valid) - int'(r_credit);
            out_used <= out_used + int'(pop) - int'(a_credit);
        end
    end

    // from the second reset cycle on, all registers are cleared
    reset_quiet: assert property (@(posedge clk)
        (!rst_n && in_reset_q) |-> (!r_credit && !a_valid && !pop))
        else $error("r_credit, a_valid or pop high during reset");

    out_bound: assert property (@(posedge clk) disable iff (!rst_n)
        out_used <= agen_pkg::agen_out_credits)
        else $error("more results outstanding than downstream credits");

    no_full_write: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid |-> (in_used < agen_pkg::agen_in_credits))
        else $error("request written while the input FIFO is full");

endmodule

bind address_generation_top agen_asserts asserts0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .r_valid  (r_valid),
    .r_credit (r_credit),
    .pop      (pop),
    .a_valid  (a_valid),
    .a_credit (a_credit)
);

//--- tests/tb_address_generation.sv
// testbench for the address generation stage
// random register state, queue based reference model, credit driven stimulus
`timescale 1ns/1ps

module tb_address_generation;

    localparam int timeout_cycles = 200;

    logic                   clk;
    logic                   rst_n;
    logic                   r_valid;
    agen_pkg::agen_req_t    r_req;
    agen_pkg::arch_state_t  arch;
    logic                   a_credit;
    logic                   r_credit;
    logic                   a_valid;
    agen_pkg::agen_result_t a_result;

    agen_pkg::agen_result_t exp_q[$];
    int   seed;
    int   sent;
    int   credits_seen;
    int   valids_seen;
    int   returned;
    int   base;
    logic give_back;

    address_generation_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .r_valid  (r_valid),
        .r_req    (r_req),
        .arch     (arch),
        .a_credit (a_credit),
        .r_credit (r_credit),
        .a_valid  (a_valid),
        .a_result (a_result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    // al..bl low bytes, ah..bh high bytes of eax..ebx
    function automatic logic [63:0] gpr_value(logic [2:0] size, logic [2:0] idx);
        case (size)
            3'd1: return idx[2] ? 64'(arch.gpr[idx[1:0]].dword[15:8])
                                : 64'(arch.gpr[idx[1:0]].dword[7:0]);
            3'd2: return 64'(arch.gpr[idx].dword[15:0]);
            3'd3: return 64'(arch.gpr[idx].dword);
            default: return 64'd0;
        endcase
    endfunction

    function automatic logic [15:0] seg_of(logic [2:0] idx);
        return (idx < 3'd6) ? arch.segs[idx] : 16'd0;
    endfunction

    // address flag in the top bit
    function automatic logic [64:0] operand(logic [2:0] kind, logic [2:0] idx,
                                            agen_pkg::agen_req_t req, logic [31:0] addr);
        case (kind)
            agen_pkg::kind_reg: return {1'b0, gpr_value(req.size, idx)};
            agen_pkg::kind_seg: return {1'b0, 48'd0, seg_of(idx)};
            agen_pkg::kind_imm: return {1'b0, 16'd0, req.imm};
            agen_pkg::kind_mem: return {1'b1, 32'd0, addr};
            default: return 65'd0;
        endcase
    endfunction

    function automatic agen_pkg::agen_result_t expected(agen_pkg::agen_req_t req);
        agen_pkg::agen_result_t res;
        logic [31:0]            dst;
        logic [31:0]            src;
        logic [15:0]            src_seg;
        // es:edi and ds or override:esi, segment times 16
        dst = {12'd0, arch.segs[agen_pkg::seg_es], 4'd0} + arch.gpr[7].dword;
        src_seg = req.seg_override_valid ? seg_of(req.seg_override)
                                         : arch.segs[agen_pkg::seg_ds];
        src = {12'd0, src_seg, 4'd0} + arch.gpr[6].dword;
        {res.op0_is_address, res.op0} = operand(req.op0_kind, req.op0_reg, req, dst);
        {res.op1_is_address, res.op1} = operand(req.op1_kind, req.op1_reg, req, src);
        res.alu_op = req.alu_op;
        res.pc = req.pc;
        return res;
    endfunction

    task automatic new_arch();
        for (int i = 0; i < 8; i++) begin
            arch.gpr[i].dword = $random(seed);
        end
        for (int i = 0; i < 6; i++) begin
            arch.segs[i] = 16'($random(seed));
        end
    endtask

    // one request, sent once an input credit is held
    task automatic send(input logic [2:0] size, input logic [2:0] k0, input logic [2:0] r0,
                        input logic [2:0] k1, input logic [2:0] r1, input logic [3:0] ovr);
        agen_pkg::agen_req_t req;
        int                  waited;
        waited = 0;
        while (sent - credits_seen >= agen_pkg::agen_in_credits) begin
            if (waited == timeout_cycles) begin
                stop_run("no input credit came back in time");
            end
            @(posedge clk);
            #1;
            waited++;
        end
        req.size = size;
        req.op0_kind = k0;
        req.op0_reg = r0;
        req.op1_kind = k1;
        req.op1_reg = r1;
        req.seg_override = ovr[2:0];
        req.seg_override_valid = ovr[3];
        req.imm = 48'({$random(seed), $random(seed)});
        req.alu_op = 4'($random(seed));
        req.pc = $random(seed);
        r_req = req;
        r_valid = 1'b1;
        exp_q.push_back(expected(req));
        sent++;
        @(posedge clk);
        #1;
        r_valid = 1'b0;
    endtask

    task automatic wait_results(input int target);
        int waited;
        waited = 0;
        while (valids_seen < target || (give_back && returned < valids_seen)) begin
            if (waited == timeout_cycles) begin
                stop_run($sformatf("timed out waiting for result %0d", target));
            end
            @(posedge clk);
            #1;
            waited++;
        end
        // last returned credit reaches the counter
        repeat (2) @(posedge clk);
        #1;
    endtask

    // results and input credits, sampled mid cycle
    initial begin
        credits_seen = 0;
        valids_seen = 0;
        forever begin
            @(negedge clk);
            if (rst_n && r_credit) begin
                credits_seen++;
            end
            if (rst_n && a_valid) begin
                assert (valids_seen < exp_q.size() && a_result == exp_q[valids_seen])
                    else stop_run($sformatf("FAILED at %0t: result %0d is %h, expected %h",
                                            $time, valids_seen, a_result, exp_q[valids_seen]));
                valids_seen++;
            end
        end
    end

    // downstream sink, one slot back per result when allowed
    initial begin
        a_credit = 1'b0;
        returned = 0;
        forever begin
            @(posedge clk);
            #1;
            a_credit = give_back && (valids_seen > returned);
            if (a_credit) begin
                returned++;
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        r_valid = 1'b0;
        r_req = '0;
        arch = '0;
        seed = 9;
        sent = 0;
        give_back = 1'b1;
        new_arch();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // register views, size 0 reads zero
        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < 8; i++) begin
                send(3'(s), agen_pkg::kind_reg, 3'(i), agen_pkg::kind_reg, 3'(7 - i), 4'd0);
            end
        end
        wait_results(sent);
        new_arch();
        for (int i = 0; i < 8; i++) begin
            send(3'd3, agen_pkg::kind_seg, 3'(i), agen_pkg::kind_seg, 3'(7 - i), 4'd0);
        end
        send(3'd3, agen_pkg::kind_imm, 3'd0, agen_pkg::kind_imm, 3'd0, 4'd0);
        send(3'd2, agen_pkg::kind_none, 3'd1, 3'd3, 3'd2, 4'd0);
        send(3'd1, 3'd4, 3'd3, 3'd7, 3'd4, 4'd0);
        // string addresses, overrides first, then plain ds
        for (int i = 0; i < 9; i++) begin
            send(3'd3, agen_pkg::kind_mem, 3'd0, agen_pkg::kind_mem, 3'd0,
                 (i < 8) ? {1'b1, 3'(i)} : 4'd0);
        end
        wait_results(sent);
        // no downstream credits, four results then a stall
        give_back = 1'b0;
        base = valids_seen;
        for (int i = 0; i < 6; i++) begin
            send(3'd3, agen_pkg::kind_mem, 3'd0, agen_pkg::kind_reg, 3'(i), 4'd0);
        end
        wait_results(base + 4);
        repeat (10) @(posedge clk);
        #1;
        assert (valids_seen == base + 4 && sent - credits_seen == agen_pkg::agen_in_credits)
            else stop_run($sformatf(
                "FAILED at %0t: %0d results and %0d credits held under back-pressure",
                $time, valids_seen - base, sent - credits_seen));
        give_back = 1'b1;
        wait_results(sent);
        // burst on both input credits
        send(3'd3, agen_pkg::kind_imm, 3'd0, agen_pkg::kind_reg, 3'd5, 4'd0);
        send(3'd2, agen_pkg::kind_reg, 3'd6, agen_pkg::kind_imm, 3'd0, 4'd0);
        wait_results(sent);
        if (credits_seen == sent && valids_seen == sent) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_run($sformatf("FAILED at %0t: %0d requests, %0d r_credit pulses, %0d results",
                               $time, sent, credits_seen, valids_seen));
        end
    end

endmodule
